/* mem_stage.f */
design/riscv_pkg.sv
design/mem_bus_pkg.sv
design/mem_lane_if.sv
design/load_unit.sv
design/store_unit.sv
design/mem_access_ctrl.sv
design/mem_stage.sv
tb/mem_stage_properties.sv
tb/mem_stage_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   := mem_stage.f
TOP        := mem_stage_tb
LINT_TOP   := mem_stage
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

# the simulation exits non-zero on a fatal error or a failed assertion
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tb/mem_stage_tb.sv */
`timescale 1ns/10ps

module mem_stage_tb;
  import riscv_pkg::*;
  import mem_bus_pkg::*;

  localparam int ADDR_W  = 32;
  localparam int TIMEOUT = 50;

  logic              clk_i;
  logic              reset_i;
  logic              op_valid_i;
  logic              op_ready_o;
  op_kind_e          op_kind_i;
  mem_size_e         op_size_i;
  word_t             op_pc_i;
  word_t             op_addr_i;
  word_t             op_store_data_i;
  logic              op_rd_write_i;
  logic [4:0]        op_rd_addr_i;
  logic              op_is_branch_i;
  logic              op_branch_predict_i;
  logic              op_jump_taken_i;
  logic              op_trap_valid_i;
  word_t             op_trap_mcause_i;
  logic              mem_valid_o;
  logic              mem_wen_o;
  logic [ADDR_W-1:0] mem_addr_o;
  strobe_t           mem_strb_o;
  word_t             mem_wdata_o;
  logic              mem_done_i = 1'b0;
  word_t             mem_rdata_i = '0;
  logic              result_valid_o;
  logic              result_ready_i;
  logic              result_rd_write_o;
  logic [4:0]        result_rd_addr_o;
  word_t             result_rd_wdata_o;
  logic              result_trap_valid_o;
  word_t             result_trap_mcause_o;
  word_t             result_trap_pc_o;
  logic              result_mispredict_o;

  word_t       mem_model [16];
  logic [1:0]  wait_cnt;
  logic [31:0] lcg_state = 32'hfcb7f076;

  // first memory request seen during the last operation
  logic              saw_mem;
  logic              seen_wen;
  logic [ADDR_W-1:0] seen_addr;
  strobe_t           seen_strb;
  word_t             seen_wdata;

  mem_stage #(.ADDR_W(ADDR_W)) i_mem_stage (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_range(input int unsigned n);
    return (lcg_next() >> 8) % n;
  endfunction

  function automatic word_t fill_word(input int i);
    return 32'h9e37_79b9 * (i + 1) ^ (i << 20);
  endfunction

  // ************************************************************************
  // data memory model with 0 to 3 wait cycles
  // ************************************************************************
  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      mem_done_i <= 1'b0;
      wait_cnt   <= 2'd0;
      for (int i = 0; i < 16; i++)
        mem_model[i] <= fill_word(i);
    end
    else if (mem_valid_o && mem_done_i)
    begin
      if (mem_wen_o)
        for (int b = 0; b < 4; b++)
          if (mem_strb_o[b])
            mem_model[mem_addr_o[5:2]][8*b +: 8] <= mem_wdata_o[8*b +: 8];
      mem_done_i <= 1'b0;
      wait_cnt   <= 2'(rand_range(4));
    end
    else if (mem_valid_o)
    begin
      if (wait_cnt == 2'd0)
      begin
        mem_done_i  <= 1'b1;
        mem_rdata_i <= mem_model[mem_addr_o[5:2]];
      end
      else
        wait_cnt <= wait_cnt - 2'd1;
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_strobe(input string name, input strobe_t got, input strobe_t exp);
    if (got !== exp)
      fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  // expected load value, straight from the byte layout of the word
  function automatic word_t load_expect(input word_t w, input int off, input mem_size_e size);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[8*off +: 8];
    h = (off >= 2) ? w[31:16] : w[15:0];
    case (size)
      SIZE_B:  return {{24{b[7]}}, b};
      SIZE_BU: return {24'h0, b};
      SIZE_H:  return {{16{h[15]}}, h};
      SIZE_HU: return {16'h0, h};
      default: return w;
    endcase
  endfunction

  task automatic set_op(input op_kind_e kind, input mem_size_e size, input word_t pc,
                        input word_t addr, input word_t data);
    op_kind_i           <= kind;
    op_size_i           <= size;
    op_pc_i             <= pc;
    op_addr_i           <= addr;
    op_store_data_i     <= data;
    op_rd_write_i       <= (kind != OP_STORE);
    op_rd_addr_i        <= 5'd10;
    op_is_branch_i      <= 1'b0;
    op_branch_predict_i <= 1'b0;
    op_jump_taken_i     <= 1'b0;
    op_trap_valid_i     <= 1'b0;
    op_trap_mcause_i    <= '0;
  endtask

  // hand over one operation and return on the cycle its result is offered
  task automatic run_op();
    int n;
    saw_mem = 1'b0;
    op_valid_i <= 1'b1;
    n = 0;
    do
    begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        fail_run("operation was never accepted");
    end
    while (!op_ready_o);
    op_valid_i <= 1'b0;
    n = 0;
    do
    begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        fail_run("no result came back after the operation was accepted");
      if (mem_valid_o && !saw_mem)
      begin
        saw_mem    = 1'b1;
        seen_wen   = mem_wen_o;
        seen_addr  = mem_addr_o;
        seen_strb  = mem_strb_o;
        seen_wdata = mem_wdata_o;
      end
    end
    while (!result_valid_o);
  endtask

  task automatic verify_load(input word_t addr, input mem_size_e size);
    word_t   exp;
    strobe_t exp_strb;
    exp = load_expect(mem_model[addr[5:2]], int'(addr[1:0]), size);
    if ((size == SIZE_B) || (size == SIZE_BU))
      exp_strb = strobe_t'(4'b0001 << addr[1:0]);
    else
      exp_strb = strobe_t'(4'b0011 << addr[1:0]);
    set_op(OP_LOAD, size, 32'h0000_0300, addr, 32'h0);
    run_op();
    check_bit("mem_valid_o", saw_mem, 1'b1);
    check_bit("mem_wen_o", seen_wen, 1'b0);
    check_word("mem_addr_o", word_t'(seen_addr), addr);
    check_strobe("mem_strb_o", seen_strb, exp_strb);
    check_bit("result_rd_write_o", result_rd_write_o, 1'b1);
    check_word("result_rd_wdata_o", result_rd_wdata_o, exp);
  endtask

  task automatic trap_case(input op_kind_e kind, input mem_size_e size, input word_t addr,
                           input word_t cause);
    set_op(kind, size, 32'h0000_0400 + addr, addr, 32'h1234_5678);
    op_rd_write_i <= 1'b1;
    run_op();
    check_bit("mem_valid_o", saw_mem, 1'b0);
    check_bit("result_trap_valid_o", result_trap_valid_o, 1'b1);
    check_word("result_trap_mcause_o", result_trap_mcause_o, cause);
    check_word("result_trap_pc_o", result_trap_pc_o, 32'h0000_0400 + addr);
    check_bit("result_rd_write_o", result_rd_write_o, 1'b0);
  endtask

  task automatic branch_case(input logic is_branch, input logic predict, input logic taken,
                             input logic exp);
    set_op(OP_ALU, SIZE_NONE, 32'h0000_0500, 32'h0000_0040, 32'h0);
    op_is_branch_i      <= is_branch;
    op_branch_predict_i <= predict;
    op_jump_taken_i     <= taken;
    run_op();
    check_bit("result_mispredict_o", result_mispredict_o, exp);
  endtask

  // ************************************************************************
  // directed tests
  // ************************************************************************
  task automatic word_roundtrip();
    set_op(OP_STORE, SIZE_W, 32'h0000_0100, 32'h0000_0020, 32'hcafe_f00d);
    run_op();
    check_bit("mem_valid_o", saw_mem, 1'b1);
    check_bit("mem_wen_o", seen_wen, 1'b1);
    check_word("mem_addr_o", word_t'(seen_addr), 32'h0000_0020);
    check_strobe("mem_strb_o", seen_strb, 4'hf);
    check_word("mem_wdata_o", seen_wdata, 32'hcafe_f00d);
    check_bit("result_trap_valid_o", result_trap_valid_o, 1'b0);
    set_op(OP_LOAD, SIZE_W, 32'h0000_0104, 32'h0000_0020, 32'h0);
    run_op();
    check_bit("mem_wen_o", seen_wen, 1'b0);
    check_bit("result_rd_write_o", result_rd_write_o, 1'b1);
    check_word("result_rd_wdata_o", result_rd_wdata_o, 32'hcafe_f00d);
  endtask

  task automatic narrow_access();
    logic [7:0]  bdata;
    logic [15:0] hdata;
    for (int off = 0; off < 4; off++)
    begin
      bdata = 8'h90 + 8'(off * 17);
      set_op(OP_STORE, SIZE_B, 32'h0000_0200, 32'h0000_0030 + off, {24'h5a5a5a, bdata});
      run_op();
      check_bit("mem_wen_o", seen_wen, 1'b1);
      check_strobe("mem_strb_o", seen_strb, strobe_t'(4'b0001 << off));
      check_word("mem_wdata_o", seen_wdata, {4{bdata}});
    end
    for (int off = 0; off < 4; off += 2)
    begin
      hdata = 16'h8421 + 16'(off);
      set_op(OP_STORE, SIZE_H, 32'h0000_0210, 32'h0000_0034 + off, {16'h7e7e, hdata});
      run_op();
      check_strobe("mem_strb_o", seen_strb, strobe_t'(4'b0011 << off));
      check_word("mem_wdata_o", seen_wdata, {2{hdata}});
    end
    check_word("mem_model[12]", mem_model[12], 32'hc3b2_a190);
    check_word("mem_model[13]", mem_model[13], 32'h8423_8421);
    for (int off = 0; off < 4; off++)
    begin
      verify_load(32'h0000_0030 + off, SIZE_B);
      verify_load(32'h0000_0030 + off, SIZE_BU);
    end
    for (int off = 0; off < 4; off += 2)
    begin
      verify_load(32'h0000_0034 + off, SIZE_H);
      verify_load(32'h0000_0034 + off, SIZE_HU);
    end
    // untouched words still hold the fill pattern
    verify_load(32'h0000_000b, SIZE_B);
    verify_load(32'h0000_000e, SIZE_HU);
  endtask

  task automatic misaligned_traps();
    trap_case(OP_LOAD, SIZE_H, 32'h0000_0041, 32'd4);
    trap_case(OP_LOAD, SIZE_HU, 32'h0000_0043, 32'd4);
    trap_case(OP_LOAD, SIZE_W, 32'h0000_0042, 32'd4);
    trap_case(OP_STORE, SIZE_W, 32'h0000_0043, 32'd6);
    trap_case(OP_STORE, SIZE_H, 32'h0000_0045, 32'd6);
  endtask

  task automatic trap_priority_and_writeback();
    set_op(OP_STORE, SIZE_W, 32'h0000_0500, 32'h0000_0021, 32'h1);
    op_rd_write_i    <= 1'b1;
    op_trap_valid_i  <= 1'b1;
    op_trap_mcause_i <= 32'd2;
    run_op();
    check_bit("mem_valid_o", saw_mem, 1'b0);
    check_bit("result_trap_valid_o", result_trap_valid_o, 1'b1);
    check_word("result_trap_mcause_o", result_trap_mcause_o, 32'd2);
    check_word("result_trap_pc_o", result_trap_pc_o, 32'h0000_0500);
    check_bit("result_rd_write_o", result_rd_write_o, 1'b0);
    set_op(OP_JUMP, SIZE_NONE, 32'h0000_0ffc, 32'h0000_1234, 32'h0);
    run_op();
    check_bit("mem_valid_o", saw_mem, 1'b0);
    check_bit("result_trap_valid_o", result_trap_valid_o, 1'b0);
    check_bit("result_rd_write_o", result_rd_write_o, 1'b1);
    check_word("result_rd_wdata_o", result_rd_wdata_o, 32'h0000_1000);
    set_op(OP_ALU, SIZE_NONE, 32'h0000_0600, 32'hdead_beef, 32'h0);
    run_op();
    check_bit("mem_valid_o", saw_mem, 1'b0);
    check_word("result_rd_wdata_o", result_rd_wdata_o, 32'hdead_beef);
  endtask

  task automatic mispredict_flags();
    branch_case(1'b1, 1'b1, 1'b0, 1'b1);
    branch_case(1'b1, 1'b0, 1'b1, 1'b1);
    branch_case(1'b1, 1'b1, 1'b1, 1'b0);
    branch_case(1'b0, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic stall_and_order();
    int    hold;
    word_t addr;
    result_ready_i <= 1'b0;
    set_op(OP_LOAD, SIZE_W, 32'h0000_0700, 32'h0000_0020, 32'h0);
    run_op();
    // next operation waits behind the stalled result
    set_op(OP_LOAD, SIZE_W, 32'h0000_0704, 32'h0000_0010, 32'h0);
    op_valid_i <= 1'b1;
    hold = 1 + int'(rand_range(6));
    for (int i = 0; i < hold; i++)
    begin
      @(posedge clk_i);
      check_bit("result_valid_o", result_valid_o, 1'b1);
      check_bit("op_ready_o", op_ready_o, 1'b0);
      check_bit("mem_valid_o", mem_valid_o, 1'b0);
      check_word("result_rd_wdata_o", result_rd_wdata_o, 32'hcafe_f00d);
      check_bit("result_rd_write_o", result_rd_write_o, 1'b1);
    end
    result_ready_i <= 1'b1;
    run_op();
    check_word("result_rd_wdata_o", result_rd_wdata_o, mem_model[4]);
    for (int i = 0; i < 4; i++)
    begin
      addr = lcg_next();
      set_op(OP_ALU, SIZE_NONE, 32'h0000_0800, addr, 32'h0);
      op_rd_addr_i <= 5'(i + 1);
      run_op();
      check_word("result_rd_wdata_o", result_rd_wdata_o, addr);
      check_word("result_rd_addr_o", word_t'(result_rd_addr_o), word_t'(i + 1));
    end
  endtask

  initial
  begin
    reset_i        = 1'b1;
    op_valid_i     = 1'b0;
    result_ready_i = 1'b1;
    set_op(OP_ALU, SIZE_NONE, 32'h0, 32'h0, 32'h0);
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_bit("op_ready_o", op_ready_o, 1'b1);
    check_bit("mem_valid_o", mem_valid_o, 1'b0);
    check_bit("mem_wen_o", mem_wen_o, 1'b0);
    check_bit("result_valid_o", result_valid_o, 1'b0);
    word_roundtrip();
    narrow_access();
    misaligned_traps();
    trap_priority_and_writeback();
    mispredict_flags();
    stall_and_order();
    $display("All tests passed!");
    $finish;
  end

endmodule

/* tb/mem_stage_properties.sv */
`timescale 1ns/10ps

module mem_stage_properties #(
  parameter int ADDR_W = 32
) (
  input logic              clk_i,
  input logic              reset_i,
  input logic              accept_i,
  input logic              trap_i,
  input logic              op_ready_i,
  input logic              mem_valid_i,
  input logic              mem_done_i,
  input logic [ADDR_W-1:0] mem_addr_i,
  input logic [36:0]       mem_bits_i,
  input logic              result_valid_i,
  input logic              result_ready_i,
  input logic [103:0]      result_bits_i
);

  // request held until done, then dropped
  a_mem_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_valid_i && !mem_done_i |=> mem_valid_i && $stable(mem_addr_i) && $stable(mem_bits_i))
  else
    $error("memory request changed before done");

  a_mem_drop: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_valid_i && mem_done_i |=> !mem_valid_i)
  else
    $error("memory request stayed up after done");

  // trapping operation never reaches memory
  a_trap_no_req: assert property (@(posedge clk_i) disable iff (reset_i)
    accept_i && trap_i |=> !mem_valid_i)
  else
    $error("memory request after a trapping operation");

  a_result_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_bits_i))
  else
    $error("result changed while stalled");

  // stalled result blocks new work
  a_one_in_flight: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_i && !result_ready_i |=> !op_ready_i && !mem_valid_i)
  else
    $error("operation ready or request started while a result is stalled");

endmodule

bind mem_access_ctrl mem_stage_properties #(.ADDR_W(ADDR_W)) i_mem_stage_properties (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .accept_i       (accept),
  .trap_i         (trap_valid_d),
  .op_ready_i     (op_ready_o),
  .mem_valid_i    (mem_valid_o),
  .mem_done_i     (mem_done_i),
  .mem_addr_i     (mem_addr_o),
  .mem_bits_i     ({mem_wen_o, mem_strb_o, mem_wdata_o}),
  .result_valid_i (result_valid_o),
  .result_ready_i (result_ready_i),
  .result_bits_i  ({result_rd_write_o, result_rd_addr_o, result_rd_wdata_o,
                    result_trap_valid_o, result_trap_mcause_o, result_trap_pc_o,
                    result_mispredict_o})
);

/* design/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage #(
  parameter int ADDR_W = 32
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // operation in
  input  logic                 op_valid_i,
  output logic                 op_ready_o,
  input  riscv_pkg::op_kind_e  op_kind_i,
  input  riscv_pkg::mem_size_e op_size_i,
  input  riscv_pkg::word_t     op_pc_i,
  input  riscv_pkg::word_t     op_addr_i,
  input  riscv_pkg::word_t     op_store_data_i,
  input  logic                 op_rd_write_i,
  input  logic [4:0]           op_rd_addr_i,
  input  logic                 op_is_branch_i,
  input  logic                 op_branch_predict_i,
  input  logic                 op_jump_taken_i,
  input  logic                 op_trap_valid_i,
  input  riscv_pkg::word_t     op_trap_mcause_i,
  // data memory
  output logic                 mem_valid_o,
  output logic                 mem_wen_o,
  output logic [ADDR_W-1:0]    mem_addr_o,
  output mem_bus_pkg::strobe_t mem_strb_o,
  output riscv_pkg::word_t     mem_wdata_o,
  input  logic                 mem_done_i,
  input  riscv_pkg::word_t     mem_rdata_i,
  // result out
  output logic                 result_valid_o,
  input  logic                 result_ready_i,
  output logic                 result_rd_write_o,
  output logic [4:0]           result_rd_addr_o,
  output riscv_pkg::word_t     result_rd_wdata_o,
  output logic                 result_trap_valid_o,
  output riscv_pkg::word_t     result_trap_mcause_o,
  output riscv_pkg::word_t     result_trap_pc_o,
  output logic                 result_mispredict_o
);

  mem_lane_if #(.ADDR_W(ADDR_W)) load_lane ();
  mem_lane_if #(.ADDR_W(ADDR_W)) store_lane ();

  // ************************************************************************
  // lane units
  // ************************************************************************
  load_unit #(.ADDR_W(ADDR_W)) i_load_unit (
    .lane (load_lane)
  );

  store_unit #(.ADDR_W(ADDR_W)) i_store_unit (
    .lane (store_lane)
  );

  // ************************************************************************
  // access controller
  // ************************************************************************
  mem_access_ctrl #(.ADDR_W(ADDR_W)) i_mem_access_ctrl (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .op_valid_i           (op_valid_i),
    .op_ready_o           (op_ready_o),
    .op_kind_i            (op_kind_i),
    .op_size_i            (op_size_i),
    .op_pc_i              (op_pc_i),
    .op_addr_i            (op_addr_i),
    .op_store_data_i      (op_store_data_i),
    .op_rd_write_i        (op_rd_write_i),
    .op_rd_addr_i         (op_rd_addr_i),
    .op_is_branch_i       (op_is_branch_i),
    .op_branch_predict_i  (op_branch_predict_i),
    .op_jump_taken_i      (op_jump_taken_i),
    .op_trap_valid_i      (op_trap_valid_i),
    .op_trap_mcause_i     (op_trap_mcause_i),
    .load_lane            (load_lane),
    .store_lane           (store_lane),
    .mem_valid_o          (mem_valid_o),
    .mem_wen_o            (mem_wen_o),
    .mem_addr_o           (mem_addr_o),
    .mem_strb_o           (mem_strb_o),
    .mem_wdata_o          (mem_wdata_o),
    .mem_done_i           (mem_done_i),
    .mem_rdata_i          (mem_rdata_i),
    .result_valid_o       (result_valid_o),
    .result_ready_i       (result_ready_i),
    .result_rd_write_o    (result_rd_write_o),
    .result_rd_addr_o     (result_rd_addr_o),
    .result_rd_wdata_o    (result_rd_wdata_o),
    .result_trap_valid_o  (result_trap_valid_o),
    .result_trap_mcause_o (result_trap_mcause_o),
    .result_trap_pc_o     (result_trap_pc_o),
    .result_mispredict_o  (result_mispredict_o)
  );

endmodule

/* design/mem_access_ctrl.sv */
`timescale 1ns/10ps

module mem_access_ctrl #(
  parameter int ADDR_W = 32
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // operation in
  input  logic                 op_valid_i,
  output logic                 op_ready_o,
  input  riscv_pkg::op_kind_e  op_kind_i,
  input  riscv_pkg::mem_size_e op_size_i,
  input  riscv_pkg::word_t     op_pc_i,
  input  riscv_pkg::word_t     op_addr_i,
  input  riscv_pkg::word_t     op_store_data_i,
  input  logic                 op_rd_write_i,
  input  logic [4:0]           op_rd_addr_i,
  input  logic                 op_is_branch_i,
  input  logic                 op_branch_predict_i,
  input  logic                 op_jump_taken_i,
  input  logic                 op_trap_valid_i,
  input  riscv_pkg::word_t     op_trap_mcause_i,
  // lanes
  mem_lane_if.ctrl             load_lane,
  mem_lane_if.ctrl             store_lane,
  // data memory
  output logic                 mem_valid_o,
  output logic                 mem_wen_o,
  output logic [ADDR_W-1:0]    mem_addr_o,
  output mem_bus_pkg::strobe_t mem_strb_o,
  output riscv_pkg::word_t     mem_wdata_o,
  input  logic                 mem_done_i,
  input  riscv_pkg::word_t     mem_rdata_i,
  // result out
  output logic                 result_valid_o,
  input  logic                 result_ready_i,
  output logic                 result_rd_write_o,
  output logic [4:0]           result_rd_addr_o,
  output riscv_pkg::word_t     result_rd_wdata_o,
  output logic                 result_trap_valid_o,
  output riscv_pkg::word_t     result_trap_mcause_o,
  output riscv_pkg::word_t     result_trap_pc_o,
  output logic                 result_mispredict_o
);
  import riscv_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACCESS,
    S_HOLD
  } state_e;

  state_e            state_q;
  state_e            state_d;
  logic              idle;
  logic              accept;
  logic              need_mem;
  op_kind_e          kind_q;
  mem_size_e         size_q;
  word_t             addr_q;
  word_t             store_data_q;
  op_kind_e          cur_kind;
  mem_size_e         cur_size;
  word_t             cur_addr;
  logic [ADDR_W-1:0] lane_addr;
  logic              trap_valid_d;
  word_t             trap_mcause_d;

  // ************************************************************************
  // lane drive, straight from the inputs while idle so traps are known
  // at acceptance
  // ************************************************************************
  assign idle      = (state_q == S_IDLE);
  assign cur_kind  = idle ? op_kind_i : kind_q;
  assign cur_size  = idle ? op_size_i : size_q;
  assign cur_addr  = idle ? op_addr_i : addr_q;
  assign lane_addr = ADDR_W'(cur_addr);

  assign load_lane.addr  = lane_addr;
  assign load_lane.size  = (cur_kind == OP_LOAD) ? cur_size : SIZE_NONE;
  assign load_lane.raw   = mem_rdata_i;
  assign store_lane.addr = lane_addr;
  assign store_lane.size = (cur_kind == OP_STORE) ? cur_size : SIZE_NONE;
  assign store_lane.raw  = idle ? op_store_data_i : store_data_q;

  assign op_ready_o = idle;
  assign accept     = op_valid_i && idle;
  assign need_mem   = ((cur_kind == OP_LOAD) || (cur_kind == OP_STORE)) && !op_trap_valid_i
                      && !load_lane.misaligned && !store_lane.misaligned;

  // incoming trap first, then store, then load
  always_comb
  begin
    trap_valid_d  = 1'b1;
    trap_mcause_d = '0;
    if (op_trap_valid_i)
      trap_mcause_d = op_trap_mcause_i;
    else if (store_lane.misaligned)
      trap_mcause_d = TRAP_STORE_MISALIGNED;
    else if (load_lane.misaligned)
      trap_mcause_d = TRAP_LOAD_MISALIGNED;
    else
      trap_valid_d = 1'b0;
  end

  // ************************************************************************
  // FSM
  // ************************************************************************
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
      begin
        if (accept)
          state_d = need_mem ? S_ACCESS : S_HOLD;
      end
      S_ACCESS:
      begin
        if (mem_done_i)
          state_d = S_HOLD;
      end
      S_HOLD:
      begin
        if (result_ready_i)
          state_d = S_IDLE;
      end
      default:
      begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_q <= S_IDLE;
    else
      state_q <= state_d;
  end

  assign mem_valid_o    = (state_q == S_ACCESS);
  assign mem_wen_o      = (state_q == S_ACCESS) && (kind_q == OP_STORE);
  assign mem_addr_o     = lane_addr;
  assign mem_wdata_o    = store_lane.result;
  assign mem_strb_o     = (cur_kind == OP_STORE) ? store_lane.strobe : load_lane.strobe;
  assign result_valid_o = (state_q == S_HOLD);

  // held operation and result
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      kind_q               <= op_kind_i;
      size_q               <= op_size_i;
      addr_q               <= op_addr_i;
      store_data_q         <= op_store_data_i;
      result_rd_write_o    <= op_rd_write_i && !trap_valid_d;
      result_rd_addr_o     <= op_rd_addr_i;
      result_rd_wdata_o    <= (op_kind_i == OP_JUMP) ? op_pc_i + 32'd4 : op_addr_i;
      result_trap_valid_o  <= trap_valid_d;
      result_trap_mcause_o <= trap_mcause_d;
      result_trap_pc_o     <= trap_valid_d ? op_pc_i : '0;
      result_mispredict_o  <= op_is_branch_i && (op_branch_predict_i != op_jump_taken_i);
    end
    else if ((state_q == S_ACCESS) && mem_done_i && (kind_q == OP_LOAD))
    begin
      result_rd_wdata_o <= load_lane.result;
    end
  end

endmodule

/* design/store_unit.sv */
`timescale 1ns/10ps

module store_unit #(
  parameter int ADDR_W = 32
) (
  mem_lane_if.unit lane
);
  import riscv_pkg::*;
  import mem_bus_pkg::*;

  mem_word_u  wdata;
  logic [1:0] offset;

  if (ADDR_W < 3)
  begin : g_width_check
    $error("store_unit needs ADDR_W of at least 3");
  end

  assign offset = lane.addr[1:0];

  // narrow data is copied to every lane, the strobe picks the live one
  always_comb
  begin
    wdata           = '0;
    lane.strobe     = 4'b0000;
    lane.misaligned = 1'b0;
    case (lane.size)
      SIZE_B, SIZE_BU:
      begin
        wdata.bytes = {4{lane.raw[7:0]}};
        lane.strobe = 4'b0001 << offset;
      end
      SIZE_H, SIZE_HU:
      begin
        wdata.halves    = {2{lane.raw[15:0]}};
        lane.strobe     = offset[1] ? 4'b1100 : 4'b0011;
        lane.misaligned = offset[0];
      end
      SIZE_W:
      begin
        wdata           = lane.raw;
        lane.strobe     = 4'b1111;
        lane.misaligned = |offset;
      end
      default:
      begin
        wdata = '0;
      end
    endcase
  end

  assign lane.result = wdata;

endmodule

/* design/load_unit.sv */
`timescale 1ns/10ps

module load_unit #(
  parameter int ADDR_W = 32
) (
  mem_lane_if.unit lane
);
  import riscv_pkg::*;
  import mem_bus_pkg::*;

  mem_word_u   rdata;
  logic [1:0]  offset;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  if (ADDR_W < 3)
  begin : g_width_check
    $error("load_unit needs ADDR_W of at least 3");
  end

  assign rdata    = lane.raw;
  assign offset   = lane.addr[1:0];
  assign sel_byte = rdata.bytes[offset];
  assign sel_half = rdata.halves[offset[1]];

  always_comb
  begin
    lane.result     = '0;
    lane.strobe     = 4'b0000;
    lane.misaligned = 1'b0;
    case (lane.size)
      SIZE_B:
      begin
        lane.result = {{24{sel_byte[7]}}, sel_byte};
        lane.strobe = 4'b0001 << offset;
      end
      SIZE_BU:
      begin
        lane.result = {24'd0, sel_byte};
        lane.strobe = 4'b0001 << offset;
      end
      SIZE_H:
      begin
        lane.result     = {{16{sel_half[15]}}, sel_half};
        lane.strobe     = offset[1] ? 4'b1100 : 4'b0011;
        lane.misaligned = offset[0];
      end
      SIZE_HU:
      begin
        lane.result     = {16'd0, sel_half};
        lane.strobe     = offset[1] ? 4'b1100 : 4'b0011;
        lane.misaligned = offset[0];
      end
      SIZE_W:
      begin
        lane.result     = rdata;
        lane.strobe     = 4'b1111;
        lane.misaligned = |offset;
      end
      // SIZE_NONE, lane idle
      default:
      begin
        lane.result = '0;
      end
    endcase
  end

endmodule

/* design/mem_lane_if.sv */
`timescale 1ns/10ps

interface mem_lane_if #(
  parameter int ADDR_W = 32
);
  import riscv_pkg::*;
  import mem_bus_pkg::*;

  logic [ADDR_W-1:0] addr;
  mem_size_e         size;
  word_t             raw;
  word_t             result;
  strobe_t           strobe;
  logic              misaligned;

  modport ctrl (
    output addr,
    output size,
    output raw,
    input  result,
    input  strobe,
    input  misaligned
  );

  modport unit (
    input  addr,
    input  size,
    input  raw,
    output result,
    output strobe,
    output misaligned
  );

endinterface

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

  // one enable bit per byte lane
  typedef logic [3:0] strobe_t;

  // data bus word, seen as byte lanes or as halfword lanes
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } mem_word_u;

endpackage

/* design/riscv_pkg.sv */
package riscv_pkg;

  typedef logic [31:0] word_t;

  // instruction class as seen by the memory stage
  typedef enum logic [1:0] {
    OP_ALU   = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2,
    OP_JUMP  = 2'd3
  } op_kind_e;

  // access size, the U variants zero extend on loads
  typedef enum logic [2:0] {
    SIZE_NONE = 3'd0,
    SIZE_B    = 3'd1,
    SIZE_BU   = 3'd2,
    SIZE_H    = 3'd3,
    SIZE_HU   = 3'd4,
    SIZE_W    = 3'd5
  } mem_size_e;

  // mcause exception codes
  parameter word_t TRAP_LOAD_MISALIGNED  = 32'd4;
  parameter word_t TRAP_STORE_MISALIGNED = 32'd6;

endpackage
